/* icFetch.f */
icFetchPkg.sv
fetchIf.sv
fetchPcGen.sv
icacheTile.sv
instrAligner.sv
icFetchTop.sv
icFetchChecker.sv
icFetchTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= icFetchTb
LOG       ?= sim.log
FILELIST  ?= icFetch.f
BUILD     ?= obj_dir

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(BUILD)/$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD) -o $(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* icFetchTb.sv */
`timescale 1ns/10ps

module icFetchTb;

	localparam logic [31:0] lfsrSeed = 32'h3dc4;
	localparam logic [19:0] firstPc = 20'h0003c;	// halfword 6 of line 3
	localparam int waitLimit = 5000;
	localparam int streamLen = 200;
	localparam int restartCount = 4;
	localparam int restartGap = 40;

	logic                 clock = 1'b0;
	logic                 rstN = 1'b0;
	logic                 start = 1'b0;
	logic [19:0]          startPc = '0;
	logic                 instrReady = 1'b1;
	logic [127:0]         memData = '0;
	icFetchPkg::memOk_t   memOk = icFetchPkg::memOkReady;
	logic [47:0]          instr;
	icFetchPkg::instrLen_t instrLen;
	logic [19:0]          instrPc;
	logic                 instrValid;
	logic [19:0]          memAddr;
	icFetchPkg::memOpm_t  memOpm;
	logic [127:0]         memLine;
	int                   xferCount;
	int                   valueErrs;
	int                   otherErrs;
	logic                 reportDone;

	logic        runDone = 1'b0;
	logic        readyRandom = 1'b0;
	logic        aborted = 1'b0;
	int          startsWanted = 0;
	int          startsDone = 0;
	logic [31:0] lfsrState = lfsrSeed;
	logic [31:0] randVal;
	logic        memBusy = 1'b0;
	logic [1:0]  waitCnt = '0;
	logic        dropOk;
	logic        raiseOk;
	logic        readyNext;
	logic        startNext;
	logic [19:0] pcNext = '0;

	always #5 clock = ~clock;

	icFetchTop i_icFetchTop (
		.clock(clock), .rstN(rstN), .start(start), .startPc(startPc),
		.instr(instr), .instrLen(instrLen), .instrPc(instrPc),
		.instrValid(instrValid), .instrReady(instrReady),
		.memAddr(memAddr), .memOpm(memOpm), .memData(memData), .memOk(memOk)
	);

	icFetchChecker streamCheck (
		.clock(clock), .rstN(rstN), .start(start), .startPc(startPc),
		.instr(instr), .instrLen(instrLen), .instrPc(instrPc),
		.instrValid(instrValid), .instrReady(instrReady),
		.memAddr(memAddr), .memOpm(memOpm), .runDone(runDone), .memLine(memLine),
		.xferCount(xferCount), .valueErrs(valueErrs), .otherErrs(otherErrs),
		.reportDone(reportDone)
	);

	function automatic logic [31:0] galoisStep(input logic [31:0] s);
		if (s[0])
			return {1'b0, s[31:1]} ^ 32'h80200003;
		return {1'b0, s[31:1]};
	endfunction

	task automatic randBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsrState[0]};	// one step per bit
			lfsrState = galoisStep(lfsrState);
		end
	endtask

	// memory model, instrReady and start pulses, all driven 1 ns after the edge
	always @(posedge clock)
	begin
		dropOk = 1'b0;
		raiseOk = 1'b0;
		startNext = 1'b0;
		if (memOk == icFetchPkg::memOkOk)
		begin
			if (memOpm == icFetchPkg::memOpmReady)
				dropOk = 1'b1;	// tile has the line
		end
		else if (rstN && memOpm == icFetchPkg::memOpmRdTile)
		begin
			if (!memBusy)
			begin
				memBusy = 1'b1;
				randBits(2, randVal);
				waitCnt = randVal[1:0];	// latency 1 to 4
			end
			else
				waitCnt = waitCnt - 2'd1;
			if (waitCnt == 2'd0)
			begin
				memBusy = 1'b0;
				raiseOk = 1'b1;
			end
		end
		readyNext = 1'b1;
		if (readyRandom)
		begin
			randBits(1, randVal);
			readyNext = randVal[0];
		end
		if (rstN && startsDone < startsWanted)
		begin
			startNext = 1'b1;
			pcNext = firstPc;
			if (startsDone > 0)
			begin
				randBits(20, randVal);
				pcNext = {randVal[19:1], 1'b0};
			end
			startsDone++;
		end
		#1;
		if (dropOk)
			memOk = icFetchPkg::memOkReady;
		if (raiseOk)
		begin
			memData = memLine;
			memOk = icFetchPkg::memOkOk;
		end
		instrReady = readyNext;
		start = startNext;
		if (startNext)
			startPc = pcNext;
	end

	task automatic waitForXfers(input int target, input string what);
		int cycles;
		cycles = 0;
		while (!aborted && xferCount < target && cycles < waitLimit)
		begin
			@(posedge clock);
			#2;
			cycles++;
		end
		if (!aborted && xferCount < target)
		begin
			$display("timeout in %s: %0d of %0d instructions delivered", what, xferCount,
				target);
			aborted = 1'b1;
		end
	endtask

	task automatic waitForReport();
		int cycles;
		cycles = 0;
		while (!aborted && reportDone !== 1'b1 && cycles < 20)
		begin
			@(posedge clock);
			#2;
			cycles++;
		end
		if (!aborted && reportDone !== 1'b1)
		begin
			$display("timeout waiting for the end-of-run checks");
			aborted = 1'b1;
		end
	endtask

	initial
	begin
		repeat (8) @(posedge clock);
		#1 rstN = 1'b1;
		startsWanted = 1;
		waitForXfers(streamLen, "sequential stream");
		readyRandom = 1'b1;
		waitForXfers(2*streamLen, "back-pressure stream");
		for (int r = 0; r < restartCount; r++)
		begin
			startsWanted = startsWanted + 1;
			waitForXfers(xferCount + restartGap, "stream after restart");
		end
		runDone = 1'b1;
		waitForReport();
		$display("transfers %0d, value errors %0d, other errors %0d, timeout %0d",
			xferCount, valueErrs, otherErrs, aborted);
		if (aborted || valueErrs != 0 || otherErrs != 0)
			$display("*** FAILED ***");
		else
			$display("*** PASSED ***");
		$finish;
	end

endmodule

/* icFetchChecker.sv */
`timescale 1ns/10ps

module icFetchChecker (
	input  logic                              clock,
	input  logic                              rstN,
	input  logic                              start,
	input  logic [icFetchPkg::addrBits-1:0]   startPc,
	input  logic [icFetchPkg::windowBits-1:0] instr,
	input  icFetchPkg::instrLen_t             instrLen,
	input  logic [icFetchPkg::addrBits-1:0]   instrPc,
	input  logic                              instrValid,
	input  logic                              instrReady,
	input  logic [icFetchPkg::addrBits-1:0]   memAddr,
	input  icFetchPkg::memOpm_t               memOpm,
	input  logic                              runDone,
	output logic [icFetchPkg::lineBits-1:0]   memLine,
	output int                                xferCount,
	output int                                valueErrs,
	output int                                otherErrs,
	output logic                              reportDone
);

	localparam int stallLimit = 400;	// cycles without a transfer

	logic [19:0] refPc = '0;
	logic        started = 1'b0;
	logic        held = 1'b0;
	logic [47:0] prevInstr = '0;
	logic [1:0]  prevLen = '0;
	logic [19:0] prevPc = '0;
	logic [47:0] expInstr;
	logic [1:0]  expLen;
	logic [3:0]  lenSeen = '0;
	logic        crossSeen = 1'b0;
	logic        reported = 1'b0;
	logic        restartPending = 1'b0;
	int          xfers = 0;
	int          valErr = 0;
	int          othErr = 0;
	int          stall = 0;
	int          restartsChecked = 0;

	// hashed memory contents with about a quarter each of length 3 and length 2
	function automatic logic [15:0] memHalf(input logic [18:0] hAddr);
		logic [31:0] h;
		logic [15:0] w;
		h = {13'd0, hAddr} * 32'h9e3779b1;
		h = h ^ {16'd0, h[31:16]};
		w = h[15:0];
		case (h[29:28])
			2'b00: w[15:10] = 6'b111111;
			2'b01: w[15:11] = 5'b11110;
			default: w[15] = 1'b0;
		endcase
		return w;
	endfunction

	function automatic logic [1:0] refLen(input logic [15:0] first);
		if (first[15:10] == 6'b111111)
			return 2'd3;
		if (first[15:12] == 4'b1111)
			return 2'd2;
		return 2'd1;
	endfunction

	// expected instruction at pc with unused halfwords zero
	function automatic logic [47:0] refInstr(input logic [19:0] pc);
		logic [18:0] hAddr;
		logic [47:0] w;
		hAddr = pc[19:1];
		w = {memHalf(hAddr + 19'd2), memHalf(hAddr + 19'd1), memHalf(hAddr)};
		case (refLen(w[15:0]))
			2'd1: w[47:16] = '0;
			2'd2: w[47:32] = '0;
			default: ;
		endcase
		return w;
	endfunction

	always_comb
	begin
		for (int i = 0; i < 8; i++)
			memLine[16*i +: 16] = memHalf({memAddr[19:4], i[2:0]});
	end

	task automatic reportMismatch(input string name, input logic [63:0] expV,
		input logic [63:0] actV);
		$display("ERR %0t %s expected %h got %h", $time, name, expV, actV);
		valErr++;
	endtask

	always @(posedge clock)
	begin
		if (rstN)
		begin
			if (instrValid && instrReady)
			begin
				stall = 0;
				if (!started)
				begin
					$display("instruction at %h delivered before any start", instrPc);
					othErr++;
				end
				else
				begin
					expInstr = refInstr(refPc);
					expLen = refLen(expInstr[15:0]);
					if (instrPc != refPc)
						reportMismatch("instrPc", {44'd0, refPc}, {44'd0, instrPc});
					if (instrLen != expLen)
						reportMismatch("instrLen", {62'd0, expLen}, {62'd0, instrLen});
					if (instr != expInstr)
						reportMismatch("instr", {16'd0, expInstr}, {16'd0, instr});
					lenSeen[expLen] = 1'b1;
					if (refPc[3:1] >= 3'd6)
						crossSeen = 1'b1;	// window spans two lines
					if (restartPending)
					begin
						restartsChecked++;	// first output of the new stream
						restartPending = 1'b0;
					end
					refPc = refPc + {17'd0, expLen, 1'b0};
					xfers++;
				end
			end
			else if (started && !runDone)
			begin
				stall++;
				if (stall == stallLimit)
				begin
					$display("no instruction delivered for %0d cycles", stallLimit);
					othErr++;
				end
			end
			if (held && !instrValid)
			begin
				$display("instrValid dropped at %0t while the output was held", $time);
				othErr++;
			end
			else if (held && instr != prevInstr)
				reportMismatch("instr (held)", {16'd0, prevInstr}, {16'd0, instr});
			else if (held && instrLen != prevLen)
				reportMismatch("instrLen (held)", {62'd0, prevLen}, {62'd0, instrLen});
			else if (held && instrPc != prevPc)
				reportMismatch("instrPc (held)", {44'd0, prevPc}, {44'd0, instrPc});
			held = instrValid && !instrReady && !start;
			prevInstr = instr;
			prevLen = instrLen;
			prevPc = instrPc;
			if (start)
			begin
				refPc = {startPc[19:1], 1'b0};	// new stream from here
				if (started)
					restartPending = 1'b1;
				started = 1'b1;
				stall = 0;
			end
			if (memOpm != icFetchPkg::memOpmReady && memOpm != icFetchPkg::memOpmRdTile)
			begin
				$display("unknown memory opcode %h at %0t", memOpm, $time);
				othErr++;
			end
			if (memOpm == icFetchPkg::memOpmRdTile && memAddr[3:0] != 4'd0)
				reportMismatch("memAddr[3:0]", 64'd0, {60'd0, memAddr[3:0]});
			if (runDone && !reported)
			begin
				if (lenSeen[3:1] != 3'b111)
				begin
					$display("not every instruction length was seen, mask %b", lenSeen[3:1]);
					othErr++;
				end
				if (!crossSeen)
				begin
					$display("no instruction started at halfword 6 or 7 of a line");
					othErr++;
				end
				if (restartsChecked == 0)
				begin
					$display("no instruction was checked after a restart in the middle of a stream");
					othErr++;
				end
				reported = 1'b1;
			end
		end
		xferCount  <= xfers;
		valueErrs  <= valErr;
		otherErrs  <= othErr;
		reportDone <= reported;
	end

endmodule

/* icFetchTop.sv */
`timescale 1ns/10ps

module icFetchTop (
	input  logic                              clock,
	input  logic                              rstN,
	input  logic                              start,
	input  logic [icFetchPkg::addrBits-1:0]   startPc,
	output logic [icFetchPkg::windowBits-1:0] instr,
	output icFetchPkg::instrLen_t             instrLen,
	output logic [icFetchPkg::addrBits-1:0]   instrPc,
	output logic                              instrValid,
	input  logic                              instrReady,
	output logic [icFetchPkg::addrBits-1:0]   memAddr,
	output icFetchPkg::memOpm_t               memOpm,
	input  logic [icFetchPkg::lineBits-1:0]   memData,
	input  icFetchPkg::memOk_t                memOk
);

	fetchIf fetchBus ();	// PC, hit status, window and take

	fetchPcGen i_fetchPcGen (
		.clock   (clock),
		.rstN    (rstN),
		.start   (start),
		.startPc (startPc),
		.fetch   (fetchBus.pcGen)
	);

	// line buffer, only block that talks to memory
	icacheTile i_icacheTile (
		.clock   (clock),
		.rstN    (rstN),
		.fetch   (fetchBus.tile),
		.memAddr (memAddr),
		.memOpm  (memOpm),
		.memData (memData),
		.memOk   (memOk)
	);

	instrAligner i_instrAligner (
		.clock      (clock),
		.rstN       (rstN),
		.start      (start),
		.fetch      (fetchBus.aligner),
		.instr      (instr),
		.instrLen   (instrLen),
		.instrPc    (instrPc),
		.instrValid (instrValid),
		.instrReady (instrReady)
	);

endmodule

/* instrAligner.sv */
`timescale 1ns/10ps

module instrAligner (
	input  logic                              clock,
	input  logic                              rstN,
	input  logic                              start,
	fetchIf.aligner                           fetch,
	output logic [icFetchPkg::windowBits-1:0] instr,
	output icFetchPkg::instrLen_t             instrLen,
	output logic [icFetchPkg::addrBits-1:0]   instrPc,
	output logic                              instrValid,
	input  logic                              instrReady
);

	logic                              slotFree;
	logic [icFetchPkg::windowBits-1:0] masked;

	assign slotFree   = !instrValid || instrReady;	// empty or draining now
	assign fetch.take = (fetch.status == icFetchPkg::memOkOk) && slotFree && !start;

	// zero the halfwords past the decoded length
	always_comb
	begin
		masked = fetch.window;
		case (fetch.len)
			2'd1:
				masked[icFetchPkg::windowBits-1:icFetchPkg::halfBits] = '0;
			2'd2:
				masked[icFetchPkg::windowBits-1:2*icFetchPkg::halfBits] = '0;
			default:
				;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
			instrValid <= 1'b0;
		else if (start)
			instrValid <= 1'b0;	// drop whatever belongs to the old stream
		else if (fetch.take)
			instrValid <= 1'b1;
		else if (instrReady)
			instrValid <= 1'b0;
	end

	always_ff @(posedge clock)
	begin
		if (fetch.take)
		begin
			instr    <= masked;
			instrLen <= fetch.len;
			instrPc  <= fetch.pc;
		end
	end

	outputHeld: assert property (
		@(posedge clock) disable iff (!rstN)
		(instrValid && !instrReady && !start)
			|=> (instrValid && $stable(instr) && $stable(instrLen) && $stable(instrPc))
	)
	else
		$error("output changed under back-pressure");

endmodule

/* icacheTile.sv */
`timescale 1ns/10ps

module icacheTile (
	input  logic                            clock,
	input  logic                            rstN,
	fetchIf.tile                            fetch,
	output logic [icFetchPkg::addrBits-1:0] memAddr,
	output icFetchPkg::memOpm_t             memOpm,
	input  logic [icFetchPkg::lineBits-1:0] memData,
	input  icFetchPkg::memOk_t              memOk
);

	typedef enum logic [1:0] {
		fillIdle,
		fillReq,	// RD_TILE out and waiting for OK
		fillDrain	// back at READY until memory drops OK
	} fillState_t;

	// slot 0 holds even lines and slot 1 odd lines
	logic [icFetchPkg::lineBits-1:0]     lineData [2];
	logic [icFetchPkg::lineAddrBits-2:0] lineTag [2];	// line address without bit 0
	logic [1:0]                          lineValid;

	logic [icFetchPkg::lineAddrBits-1:0] pcLine;
	logic [icFetchPkg::lineAddrBits-1:0] nextLine;
	logic [2:0]                          halfIdx;
	logic                                curSel;
	logic                                nxtSel;
	logic                                curHit;
	logic                                nxtHit;
	logic                                needNext;
	logic                                missCur;
	logic                                missNxt;
	logic [2*icFetchPkg::lineBits-1:0]   pairData;

	fillState_t                          fillState;
	logic [icFetchPkg::lineAddrBits-1:0] fillLine;	// line being fetched
	logic [icFetchPkg::lineAddrBits-1:0] reqLine;

	assign pcLine   = fetch.pc[icFetchPkg::addrBits-1 -: icFetchPkg::lineAddrBits];
	assign nextLine = pcLine + {{(icFetchPkg::lineAddrBits-1){1'b0}}, 1'b1};
	assign halfIdx  = fetch.pc[3:1];

	assign curSel = pcLine[0];
	assign nxtSel = nextLine[0];

	assign curHit = lineValid[curSel]
		&& (lineTag[curSel] == pcLine[icFetchPkg::lineAddrBits-1:1]);
	assign nxtHit = lineValid[nxtSel]
		&& (lineTag[nxtSel] == nextLine[icFetchPkg::lineAddrBits-1:1]);

	// index 6 or 7 spills a 3-halfword window into the next line
	assign needNext = (halfIdx[2:1] == 2'b11);

	assign missCur = fetch.pcValid && !curHit;
	assign missNxt = fetch.pcValid && needNext && !nxtHit;

	// lower missing line first
	assign reqLine = missCur ? pcLine : nextLine;

	always_comb
	begin
		if (fetch.pcValid && !missCur && !missNxt)
			fetch.status = icFetchPkg::memOkOk;
		else
			fetch.status = icFetchPkg::memOkHold;
	end

	// current line low and next line high, slid down by the halfword index
	assign pairData     = {lineData[nxtSel], lineData[curSel]};
	assign fetch.window = pairData[{1'b0, halfIdx, 4'b0000} +: icFetchPkg::windowBits];
	assign fetch.len    = icFetchPkg::lenOf(fetch.window[icFetchPkg::halfBits-1:0]);

	assign memAddr = {fillLine, {(icFetchPkg::addrBits-icFetchPkg::lineAddrBits){1'b0}}};

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			fillState <= fillIdle;
			memOpm    <= icFetchPkg::memOpmReady;
			lineValid <= 2'b00;
		end
		else
		begin
			case (fillState)
				fillIdle:
				begin
					if (missCur || missNxt)
					begin
						memOpm    <= icFetchPkg::memOpmRdTile;
						fillState <= fillReq;
					end
				end
				fillReq:
				begin
					if (memOk == icFetchPkg::memOkOk)
					begin
						lineValid[fillLine[0]] <= 1'b1;	// hit from next cycle
						memOpm                 <= icFetchPkg::memOpmReady;
						fillState              <= fillDrain;
					end
				end
				fillDrain:
				begin
					if (memOk != icFetchPkg::memOkOk)
						fillState <= fillIdle;
				end
				default:
					fillState <= fillIdle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (fillState == fillIdle)
			fillLine <= reqLine;	// frozen once the request is out
		if (fillState == fillReq && memOk == icFetchPkg::memOkOk)
		begin
			lineData[fillLine[0]] <= memData;
			lineTag[fillLine[0]]  <= fillLine[icFetchPkg::lineAddrBits-1:1];
		end
	end

	// request and address hold until memory answers
	memAddrHeld: assert property (
		@(posedge clock) disable iff (!rstN)
		(memOpm == icFetchPkg::memOpmRdTile && memOk != icFetchPkg::memOkOk)
			|=> (memOpm == icFetchPkg::memOpmRdTile && $stable(memAddr))
	)
	else
		$error("memAddr or memOpm changed while RD_TILE was waiting");

	// memory may lag one cycle in dropping OK but no more
	memOkInRead: assert property (
		@(posedge clock) disable iff (!rstN)
		(memOk == icFetchPkg::memOkOk)
			|-> (memOpm == icFetchPkg::memOpmRdTile
				|| $past(memOpm) == icFetchPkg::memOpmRdTile)
	)
	else
		$error("memOk OK outside of RD_TILE");

endmodule

/* fetchPcGen.sv */
`timescale 1ns/10ps

module fetchPcGen (
	input  logic                            clock,
	input  logic                            rstN,
	input  logic                            start,
	input  logic [icFetchPkg::addrBits-1:0] startPc,
	fetchIf.pcGen                           fetch
);

	logic [icFetchPkg::addrBits-1:0] step;	// bytes consumed by this instruction

	// len is in halfwords, so twice that in bytes
	assign step = {{(icFetchPkg::addrBits-3){1'b0}}, fetch.len, 1'b0};

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			fetch.pcValid <= 1'b0;
			fetch.pc      <= '0;
		end
		else if (start)
		begin
			// restart wins over a take in the same cycle
			fetch.pcValid <= 1'b1;
			fetch.pc      <= {startPc[icFetchPkg::addrBits-1:1], 1'b0};
		end
		else if (fetch.take)
		begin
			fetch.pc <= fetch.pc + step;	// wraps in 20 bits
		end
	end

	// the consumer only takes a tile hit, and the tile never hits without a live PC
	takeNeedsPc: assert property (
		@(posedge clock) disable iff (!rstN)
		fetch.take |-> fetch.pcValid
	)
	else
		$error("take while pcValid is low");

endmodule

/* fetchIf.sv */
`timescale 1ns/10ps

interface fetchIf;

	logic [icFetchPkg::addrBits-1:0]   pc;		// fetch PC, halfword aligned
	logic                              pcValid;
	icFetchPkg::memOk_t                status;	// OK on a hit
	logic [icFetchPkg::windowBits-1:0] window;	// first halfword in the low bits
	icFetchPkg::instrLen_t             len;
	logic                              take;	// consumer accepts this instruction

	modport pcGen (
		output pc,
		output pcValid,
		input  len,
		input  take
	);

	modport tile (
		input  pc,
		input  pcValid,
		output status,
		output window,
		output len
	);

	modport aligner (
		input  pc,
		input  status,
		input  window,
		input  len,
		output take
	);

endinterface

/* icFetchPkg.sv */
package icFetchPkg;

	localparam int addrBits     = 20;	// byte address
	localparam int lineBits     = 128;	// 8 halfwords per line
	localparam int lineAddrBits = 16;	// address without the 4 offset bits
	localparam int windowBits   = 48;	// up to 3 halfwords
	localparam int halfBits     = 16;

	// status seen on the memory port and, from the tile, on the fetch side
	typedef enum logic [1:0] {
		memOkReady = 2'd0,
		memOkOk    = 2'd1,
		memOkHold  = 2'd2
	} memOk_t;

	typedef enum logic [4:0] {
		memOpmReady  = 5'h00,	// idle
		memOpmRdTile = 5'h0F	// read one whole line
	} memOpm_t;

	typedef logic [1:0] instrLen_t;	// halfwords, 1..3

	localparam logic [5:0] lenPrefix3 = 6'b111111;
	localparam logic [3:0] lenPrefix2 = 4'b1111;

	// length from the opcode prefix of the first halfword
	function automatic instrLen_t lenOf(input logic [halfBits-1:0] half);
		instrLen_t len;
		len = 2'd1;
		if (half[halfBits-1 -: 6] == lenPrefix3)
			len = 2'd3;
		else if (half[halfBits-1 -: 4] == lenPrefix2)
			len = 2'd2;
		return len;
	endfunction

endpackage
